// ==== design/laser_pkg.sv ====
package laser_pkg;

    // one received byte or one host byte
    typedef logic [7:0] byte_t;

    // marker sequence, most significant byte is received first
    typedef logic [31:0] marker_t;

    // payload length and idle timeout counters
    typedef logic [11:0] count_t;

    // frame kind, also the index into marker_table
    typedef enum logic [2:0] {
        kind_start,
        kind_stop,
        kind_data,
        kind_error,
        kind_done
    } marker_kind_t;

    localparam int num_markers = 5;

    // all five first bytes are distinct
    // the detector picks the marker kind from the first byte alone
    localparam marker_t marker_table [num_markers] = '{
        32'hc1c2c3c4,
        32'h51525354,
        32'hd1d2d3d4,
        32'hb1b2b3b4,
        32'ha1a2a3a4
    };

endpackage

// ==== design/marker_detector.sv ====
`timescale 1ns/1ps

module marker_detector
    import laser_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         enable,
    input  logic         byte_valid,
    input  byte_t        byte_data,
    output logic         match,
    output marker_kind_t match_kind
);

    typedef enum logic [1:0] {
        idle,
        got1,
        got2,
        got3
    } state_t;

    state_t       state;
    state_t       state_next;
    marker_kind_t kind_q;
    marker_kind_t first_kind;
    logic         first_hit;
    byte_t        expect_byte;

    // look up the first byte in the table
    // at most one entry can hit
    always_comb begin
        first_hit = 1'b0;
        first_kind = kind_start;
        for (int i = 0; i < num_markers; i++) begin
            if (byte_data == marker_table[i][31:24]) begin
                first_hit = 1'b1;
                first_kind = marker_kind_t'(i);
            end
        end
    end

    // next byte expected for the kind picked in idle
    always_comb begin
        case (state)
            got1:    expect_byte = marker_table[kind_q][23:16];
            got2:    expect_byte = marker_table[kind_q][15:8];
            default: expect_byte = marker_table[kind_q][7:0];
        endcase
    end

    // a mismatching byte goes back to idle and is not retried
    always_comb begin
        state_next = state;
        if (!enable) begin
            state_next = idle;
        end else if (byte_valid) begin
            case (state)
                idle:    state_next = first_hit ? got1 : idle;
                got1:    state_next = (byte_data == expect_byte) ? got2 : idle;
                got2:    state_next = (byte_data == expect_byte) ? got3 : idle;
                default: state_next = idle;
            endcase
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
            kind_q <= kind_start;
        end else begin
            state <= state_next;
            if (enable && byte_valid && state == idle && first_hit) begin
                kind_q <= first_kind;
            end
        end
    end

    // strobe in the same cycle as the fourth byte
    assign match = enable && byte_valid && (state == got3) && (byte_data == expect_byte);
    assign match_kind = kind_q;

endmodule

// ==== design/frame_capture.sv ====
`timescale 1ns/1ps

module frame_capture
    import laser_pkg::*;
#(
    parameter int pkt_len        = 1024,
    parameter int timeout_cycles = 1024
) (
    input  logic         clock,
    input  logic         reset,
    input  logic         byte_valid,
    input  byte_t        byte_data,
    output logic         wr_en,
    output byte_t        wr_data,
    output logic         frame_end,
    output marker_kind_t frame_kind,
    output count_t       frame_len
);

    localparam count_t pkt_last = count_t'(pkt_len - 1);
    localparam count_t idle_last = count_t'(timeout_cycles - 1);

    typedef enum logic [1:0] {
        hunt,
        load_marker,
        payload
    } state_t;

    state_t       state;
    logic         det_enable;
    logic         match;
    marker_kind_t match_kind;
    marker_kind_t kind_q;
    marker_kind_t sel_kind;
    logic [1:0]   sel_idx;
    logic [1:0]   mark_idx;
    byte_t        mark_byte;
    count_t       pay_cnt;
    count_t       idle_cnt;
    logic         last_q;

    // no hunting while a frame is open
    assign det_enable = (state == hunt);

    marker_detector u_detector (
        .clock      (clock),
        .reset      (reset),
        .enable     (det_enable),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .match      (match),
        .match_kind (match_kind)
    );

    // marker byte 0 goes out on the match itself, later ones from kind_q
    assign sel_kind = (state == hunt) ? match_kind : kind_q;
    assign sel_idx = (state == hunt) ? 2'd0 : mark_idx;
    assign mark_byte = byte_t'(marker_table[sel_kind] >> {~sel_idx, 3'b000});

    always_ff @(posedge clock) begin
        wr_data <= (state == payload) ? byte_data : mark_byte;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= hunt;
            kind_q <= kind_start;
            mark_idx <= '0;
            pay_cnt <= '0;
            idle_cnt <= '0;
            last_q <= 1'b0;
            wr_en <= 1'b0;
            frame_end <= 1'b0;
            frame_kind <= kind_start;
            frame_len <= '0;
        end else begin
            wr_en <= 1'b0;
            frame_end <= 1'b0;
            case (state)
                hunt: begin
                    if (match) begin
                        wr_en <= 1'b1;
                        kind_q <= match_kind;
                        mark_idx <= 2'd1;
                        pay_cnt <= '0;
                        idle_cnt <= '0;
                        state <= load_marker;
                    end
                end
                load_marker: begin
                    wr_en <= 1'b1;
                    mark_idx <= mark_idx + 2'd1;
                    if (mark_idx == 2'd3) begin
                        state <= payload;
                    end
                end
                default: begin
                    if (last_q) begin
                        // full length, report after the last write
                        last_q <= 1'b0;
                        frame_end <= 1'b1;
                        frame_kind <= kind_q;
                        frame_len <= pay_cnt;
                        state <= hunt;
                    end else if (byte_valid) begin
                        wr_en <= 1'b1;
                        pay_cnt <= pay_cnt + 12'd1;
                        idle_cnt <= '0;
                        if (pay_cnt == pkt_last) begin
                            last_q <= 1'b1;
                        end
                    end else if (idle_cnt == idle_last) begin
                        // frame_end lines up with idle_cnt hitting the limit
                        idle_cnt <= idle_cnt + 12'd1;
                        frame_end <= 1'b1;
                        frame_kind <= kind_q;
                        frame_len <= pay_cnt;
                        state <= hunt;
                    end else begin
                        idle_cnt <= idle_cnt + 12'd1;
                    end
                end
            endcase
        end
    end

    // the marker load needs four quiet cycles after a match
    a_byte_gap: assert property (@(posedge clock) disable iff (reset)
        byte_valid |=> !byte_valid [*4]);

    a_no_write_in_hunt: assert property (@(posedge clock) disable iff (reset)
        !(wr_en && state == hunt));

endmodule

// ==== design/byte_fifo.sv ====
`timescale 1ns/1ps

module byte_fifo
    import laser_pkg::*;
#(
    parameter int fifo_depth = 64
) (
    input  logic  clock,
    input  logic  reset,
    input  logic  wr_en,
    input  byte_t wr_data,
    input  logic  rd_en,
    output byte_t rd_data,
    output logic  empty,
    output logic  overflow
);

    localparam int addr_w = $clog2(fifo_depth);

    byte_t             mem [fifo_depth];
    logic [addr_w-1:0] wr_ptr;
    logic [addr_w-1:0] rd_ptr;
    logic [addr_w:0]   count;
    logic              full;
    logic              do_wr;
    logic              do_rd;

    assign full = (count == (addr_w + 1)'(fifo_depth));
    assign empty = (count == '0);

    // no back-pressure upstream, so a write while full is lost
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // read data lands one cycle after rd_en
    always_ff @(posedge clock) begin
        if (do_rd) begin
            rd_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (wr_en && full) begin
                overflow <= 1'b1;
            end
        end
    end

    a_no_read_empty: assert property (@(posedge clock) disable iff (reset)
        rd_en |-> !empty);

endmodule

// ==== design/host_writer.sv ====
`timescale 1ns/1ps

module host_writer
    import laser_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  empty,
    input  byte_t rd_data,
    input  logic  host_ready,
    output logic  rd_en,
    output logic  host_wr,
    output byte_t host_data
);

    typedef enum logic [1:0] {
        idle,
        fetch,
        drive,
        recover
    } state_t;

    state_t state;

    // pop straight from idle when the host can take a byte
    assign rd_en = (state == idle) && !empty && host_ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
            host_wr <= 1'b0;
        end else begin
            host_wr <= (state == fetch);
            case (state)
                idle:    state <= rd_en ? fetch : idle;
                fetch:   state <= drive;
                drive:   state <= recover;
                default: state <= idle;
            endcase
        end
    end

    // buffer data is valid in fetch, held through the strobe
    always_ff @(posedge clock) begin
        if (state == fetch) begin
            host_data <= rd_data;
        end
    end

    a_single_strobe: assert property (@(posedge clock) disable iff (reset)
        host_wr |=> !host_wr);

endmodule

// ==== design/laser_rx_top.sv ====
`timescale 1ns/1ps

module laser_rx_top
    import laser_pkg::*;
#(
    parameter int pkt_len        = 1024,
    parameter int timeout_cycles = 1024,
    parameter int fifo_depth     = 64
) (
    input  logic         clock,
    input  logic         reset,
    input  logic         byte_valid,
    input  byte_t        byte_data,
    input  logic         host_ready,
    output logic         host_wr,
    output byte_t        host_data,
    output logic         frame_end,
    output marker_kind_t frame_kind,
    output count_t       frame_len,
    output logic         overflow
);

    logic  wr_en;
    byte_t wr_data;
    logic  rd_en;
    byte_t rd_data;
    logic  empty;

    // producer side
    frame_capture #(
        .pkt_len        (pkt_len),
        .timeout_cycles (timeout_cycles)
    ) u_capture (
        .clock      (clock),
        .reset      (reset),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .frame_end  (frame_end),
        .frame_kind (frame_kind),
        .frame_len  (frame_len)
    );

    byte_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .clock    (clock),
        .reset    (reset),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .empty    (empty),
        .overflow (overflow)
    );

    // consumer side toward the host bus
    host_writer u_writer (
        .clock      (clock),
        .reset      (reset),
        .empty      (empty),
        .rd_data    (rd_data),
        .host_ready (host_ready),
        .rd_en      (rd_en),
        .host_wr    (host_wr),
        .host_data  (host_data)
    );

endmodule

// ==== bench/rx_monitor.sv ====
`timescale 1ns/1ps

module rx_monitor
    import laser_pkg::*;
#(
    parameter int           pkt_len        = 16,
    parameter int           timeout_cycles = 64,
    parameter int           fifo_depth     = 32,
    parameter logic [159:0] marker_values  = '0
) (
    input  logic         clock,
    input  logic         reset,
    input  logic         byte_valid,
    input  byte_t        byte_data,
    input  logic         host_wr,
    input  byte_t        host_data,
    input  logic         frame_end,
    input  marker_kind_t frame_kind,
    input  count_t       frame_len,
    input  logic         overflow,
    input  logic         check_now,
    output int           pending_bytes,
    output int           pending_frames,
    output logic         frame_open,
    output int           error_count,
    output int           check_count
);

    byte_t exp_bytes [$];
    int    exp_kinds [$];
    int    exp_lens [$];
    int    match_pos;
    int    match_kind;
    int    pay_cnt;
    int    idle_cnt;
    logic  exp_overflow;

    // byte j of marker k, j = 0 is received first
    function automatic byte_t marker_byte(input int k, input int j);
        return marker_values[k * 32 + 24 - 8 * j +: 8];
    endfunction

    // the buffer holds fifo_depth bytes, later ones are lost
    task automatic store_byte(input byte_t b);
        if (exp_bytes.size() >= fifo_depth) begin
            exp_overflow = 1'b1;
        end else begin
            exp_bytes.push_back(b);
        end
    endtask

    task automatic close_frame();
        exp_kinds.push_back(match_kind);
        exp_lens.push_back(pay_cnt);
        frame_open = 1'b0;
    endtask

    // a wrong byte drops back to idle and is not tried as a first byte
    task automatic hunt_byte(input byte_t b);
        if (match_pos == 0) begin
            for (int k = 0; k < 5; k++) begin
                if (b == marker_byte(k, 0)) begin
                    match_kind = k;
                    match_pos = 1;
                end
            end
        end else if (b == marker_byte(match_kind, match_pos)) begin
            match_pos++;
            if (match_pos == 4) begin
                for (int j = 0; j < 4; j++) begin
                    store_byte(marker_byte(match_kind, j));
                end
                frame_open = 1'b1;
                pay_cnt = 0;
                idle_cnt = 0;
                match_pos = 0;
            end
        end else begin
            match_pos = 0;
        end
    endtask

    task automatic check_host();
        byte_t b;
        if (exp_bytes.size() == 0) begin
            $display("unexpected host_wr at %0t, no byte was left to send", $time);
            error_count++;
        end else begin
            b = exp_bytes.pop_front();
            check_count++;
            if (host_data !== b) begin
                $display("error at %0t: host_data expected %h, got %h", $time, b, host_data);
                error_count++;
            end
        end
    endtask

    task automatic check_frame();
        int k;
        int n;
        if (exp_kinds.size() == 0) begin
            $display("unexpected frame_end at %0t, no frame was expected", $time);
            error_count++;
        end else begin
            k = exp_kinds.pop_front();
            n = exp_lens.pop_front();
            check_count++;
            if (int'(frame_kind) != k) begin
                $display("error at %0t: frame_kind expected %0d, got %0d", $time, k, frame_kind);
                error_count++;
            end
            if (int'(frame_len) != n) begin
                $display("error at %0t: frame_len expected %0d, got %0d", $time, n, frame_len);
                error_count++;
            end
        end
    endtask

    task automatic final_report();
        if (overflow !== exp_overflow) begin
            $display("error at %0t: overflow expected %b, got %b", $time, exp_overflow, overflow);
            error_count++;
        end
        if (exp_bytes.size() != 0 || exp_kinds.size() != 0 || frame_open) begin
            $display("%0d host bytes and %0d frame reports never arrived",
                     exp_bytes.size(), exp_kinds.size());
            error_count++;
        end
    endtask

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            exp_bytes.delete();
            exp_kinds.delete();
            exp_lens.delete();
            match_pos = 0;
            match_kind = 0;
            pay_cnt = 0;
            idle_cnt = 0;
            frame_open = 1'b0;
            exp_overflow = 1'b0;
            error_count = 0;
            check_count = 0;
        end else begin
            // earlier writes have settled by the next strobe
            if (byte_valid && overflow !== exp_overflow) begin
                $display("error at %0t: overflow expected %b, got %b",
                         $time, exp_overflow, overflow);
                error_count++;
            end
            if (host_wr) begin
                check_host();
            end
            if (frame_end) begin
                check_frame();
            end
            if (frame_open) begin
                if (byte_valid) begin
                    store_byte(byte_data);
                    pay_cnt++;
                    idle_cnt = 0;
                    if (pay_cnt == pkt_len) begin
                        close_frame();
                    end
                end else begin
                    idle_cnt++;
                    if (idle_cnt >= timeout_cycles) begin
                        close_frame();
                    end
                end
            end else if (byte_valid) begin
                hunt_byte(byte_data);
            end
            if (check_now) begin
                final_report();
            end
        end
        pending_bytes = exp_bytes.size();
        pending_frames = exp_kinds.size();
    end

endmodule

// ==== bench/tb_laser_rx.sv ====
`timescale 1ns/1ps

module tb_laser_rx;
    import laser_pkg::*;

    localparam int pkt_len        = 16;
    localparam int timeout_cycles = 64;
    localparam int fifo_depth     = 32;

    // start marker in the low word, done in the high word
    localparam logic [159:0] marker_values = {
        32'ha1a2a3a4, 32'hb1b2b3b4, 32'hd1d2d3d4, 32'h51525354, 32'hc1c2c3c4
    };

    // noise is sent from bit 63 down, kind -1 means no marker
    // ready 0 keeps host_ready high, 1 random, 2 held low
    typedef struct {
        logic [63:0] noise;
        int          noise_len;
        int          kind;
        int          pay;
        int          gap;
        int          ready;
    } row_t;

    logic         clock;
    logic         reset;
    logic         byte_valid;
    byte_t        byte_data;
    logic         host_ready;
    logic         host_wr;
    byte_t        host_data;
    logic         frame_end;
    marker_kind_t frame_kind;
    count_t       frame_len;
    logic         overflow;
    logic         check_now;
    logic         frame_open;
    int           pending_bytes;
    int           pending_frames;
    int           error_count;
    int           check_count;
    int           ready_mode;
    int           tb_errors;
    row_t         rows [$];

    laser_rx_top #(
        .pkt_len        (pkt_len),
        .timeout_cycles (timeout_cycles),
        .fifo_depth     (fifo_depth)
    ) u_dut (
        .clock      (clock),
        .reset      (reset),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .host_ready (host_ready),
        .host_wr    (host_wr),
        .host_data  (host_data),
        .frame_end  (frame_end),
        .frame_kind (frame_kind),
        .frame_len  (frame_len),
        .overflow   (overflow)
    );

    rx_monitor #(
        .pkt_len        (pkt_len),
        .timeout_cycles (timeout_cycles),
        .fifo_depth     (fifo_depth),
        .marker_values  (marker_values)
    ) u_mon (
        .clock          (clock),
        .reset          (reset),
        .byte_valid     (byte_valid),
        .byte_data      (byte_data),
        .host_wr        (host_wr),
        .host_data      (host_data),
        .frame_end      (frame_end),
        .frame_kind     (frame_kind),
        .frame_len      (frame_len),
        .overflow       (overflow),
        .check_now      (check_now),
        .pending_bytes  (pending_bytes),
        .pending_frames (pending_frames),
        .frame_open     (frame_open),
        .error_count    (error_count),
        .check_count    (check_count)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // host side, new value every cycle
    initial begin
        int mode;
        forever begin
            @(posedge clock);
            // ready_mode only moves 5 ns after an edge
            mode = ready_mode;
            #5;
            case (mode)
                1: host_ready = 1'($urandom);
                2: host_ready = 1'b0;
                default: host_ready = 1'b1;
            endcase
        end
    end

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clock);
            #5;
        end
    endtask

    // one strobe, then quiet until six cycles have passed
    task automatic send_byte(input byte_t b);
        byte_valid = 1'b1;
        byte_data = b;
        step(1);
        byte_valid = 1'b0;
        step(5);
    endtask

    task automatic drain_host(input int limit);
        int n;
        n = 0;
        while ((pending_bytes != 0 || pending_frames != 0 || frame_open) && n < limit) begin
            step(1);
            n++;
        end
        if (pending_bytes != 0 || pending_frames != 0 || frame_open) begin
            $display("timeout at %0t: host bytes or frame reports still pending", $time);
            tb_errors++;
        end
    endtask

    task automatic add_row(input logic [63:0] noise, input int noise_len, input int kind,
                           input int pay, input int gap, input int ready);
        row_t r;
        r.noise = noise;
        r.noise_len = noise_len;
        r.kind = kind;
        r.pay = pay;
        r.gap = gap;
        r.ready = ready;
        rows.push_back(r);
    endtask

    initial begin
        row_t        r;
        int unsigned seed_ret;
        int          total;
        reset = 1'b1;
        byte_valid = 1'b0;
        byte_data = '0;
        host_ready = 1'b1;
        check_now = 1'b0;
        ready_mode = 0;
        tb_errors = 0;
        seed_ret = $urandom(32'h820a_7569);
        // one full frame of each kind
        add_row(64'h0, 0, 0, 16, 12, 0);
        add_row(64'h0, 0, 1, 16, 12, 1);
        add_row(64'h0, 0, 2, 16, 12, 0);
        add_row(64'h0, 0, 3, 16, 12, 1);
        add_row(64'h0, 0, 4, 16, 12, 0);
        // d1 as wrong third byte of start must not open a data frame
        add_row(64'hc1c2_d1d2_d3d4_0000, 6, -1, 0, 12, 0);
        add_row(64'h5152_5300_a1a2_a300, 8, -1, 0, 12, 0);
        // short frame, ends on the idle timeout
        add_row(64'h0, 0, 2, 5, 100, 0);
        // back to back, stray bytes in between
        add_row(64'h0, 0, 3, 16, 0, 0);
        add_row(64'h1234_5600_0000_0000, 3, 4, 16, 0, 1);
        add_row(64'h0, 0, 0, 16, 12, 0);
        // host stalled over two frames fills the buffer
        add_row(64'h0, 0, 0, 16, 12, 2);
        add_row(64'h0, 0, 1, 16, 12, 2);
        add_row(64'h0, 0, -1, 0, 20, 0);

        repeat (16) @(posedge clock);
        #5;
        reset = 1'b0;
        step(4);

        foreach (rows[i]) begin
            r = rows[i];
            if (r.ready == 2 && ready_mode != 2) begin
                drain_host(1000);
            end
            ready_mode = r.ready;
            for (int n = 0; n < r.noise_len; n++) begin
                send_byte(r.noise[63 - 8 * n -: 8]);
            end
            if (r.kind >= 0) begin
                for (int j = 0; j < 4; j++) begin
                    send_byte(marker_values[r.kind * 32 + 24 - 8 * j +: 8]);
                end
            end
            for (int p = 0; p < r.pay; p++) begin
                send_byte(byte_t'($urandom));
            end
            step(r.gap);
        end

        ready_mode = 0;
        drain_host(2000);
        check_now = 1'b1;
        step(1);
        check_now = 1'b0;
        step(1);

        total = error_count + tb_errors;
        $display("checks %0d, errors %0d", check_count, total);
        if (total == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
design/laser_pkg.sv
design/marker_detector.sv
design/frame_capture.sv
design/byte_fifo.sv
design/host_writer.sv
design/laser_rx_top.sv
bench/rx_monitor.sv
bench/tb_laser_rx.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile the laser receive testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_laser_rx -f build.f -Mdir obj_dir -o tb_laser_rx; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_laser_rx > "$log" 2>&1
status=$?
cat "$log"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$log"; then
    exit 0
fi

echo "pass message not found in $log"
exit 1
